/* tb.f */
hdl/video_pkg.sv
hdl/clock_cfg_pkg.sv
hdl/board_control.sv
hdl/pll_config_encoder.sv
hdl/video_pin_mapper.sv
hdl/display_top.sv
testbench/display_top_asserts.sv
testbench/tb_display_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_display_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_display_top.sv */
// assumes the small RESET_STRETCH and HEARTBEAT_PERIOD set here; outputs read 2 ns after edges
`timescale 1ns/1ps

module tb_display_top
    import video_pkg::*, clock_cfg_pkg::*;
();

    localparam int reset_stretch    = 8;
    localparam int heartbeat_period = 15;
    localparam int drive_delay      = 2;
    localparam int cfg_rows         = 6;
    localparam int video_rows       = 16;
    localparam int ready_wait_limit = 20;
    localparam int watchdog_cycles  = (cfg_rows + video_rows) * 20 + 500;

    typedef struct packed {
        divider_t      input_div;
        divider_t      output_div;
        divider_t      feedback_div;
        logic          use_half;
        pll_sel_t      exp_idsel;
        pll_sel_t      exp_odsel;
        pll_sel_t      exp_fbdsel;
        clock_select_t exp_clock_sel;
    } cfg_row_t;

    typedef struct packed {
        logic   alt;
        logic   rnd;
        pixel_t pixel;
        logic   hsync;
        logic   vsync;
        logic   de;
    } video_row_t;

    // selects are 64 minus the low six divider bits, output divider halved first
    cfg_row_t cfg_table [cfg_rows] = '{
        '{16'd5, 16'd10, 16'd40, 1'b0, 6'd59, 6'd59, 6'd24, 4'b0001},
        '{16'd1, 16'd2, 16'd20, 1'b1, 6'd63, 6'd63, 6'd44, 4'b0010},
        // upper divider bits ignored
        '{16'h0103, 16'h0030, 16'hff3f, 1'b0, 6'd61, 6'd40, 6'd1, 4'b0001},
        '{16'd4, 16'd60, 16'd8, 1'b1, 6'd60, 6'd34, 6'd56, 4'b0010},
        // odd output divider rounds down
        '{16'd2, 16'd7, 16'd33, 1'b0, 6'd62, 6'd61, 6'd31, 4'b0001},
        '{16'd12, 16'd63, 16'd50, 1'b1, 6'd52, 6'd33, 6'd14, 4'b0010}
    };

    // straight board rows first, then the alternate board
    video_row_t video_table [video_rows] = '{
        '{1'b0, 1'b0, 24'h123456, 1'b1, 1'b0, 1'b1},
        '{1'b0, 1'b0, 24'hffc000, 1'b0, 1'b1, 1'b0},
        '{1'b0, 1'b0, 24'h003fff, 1'b1, 1'b1, 1'b1},
        '{1'b0, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        // single bits walk to their new place
        '{1'b1, 1'b0, 24'h400000, 1'b1, 1'b0, 1'b1},
        '{1'b1, 1'b0, 24'h800000, 1'b0, 1'b1, 1'b1},
        '{1'b1, 1'b0, 24'h554000, 1'b1, 1'b0, 1'b0},
        '{1'b1, 1'b0, 24'haabfff, 1'b0, 1'b0, 1'b1},
        '{1'b1, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b1, 24'h000000, 1'b0, 1'b0, 1'b0}
    };

    // output bits 14..23 take these input bits on the alternate board
    localparam int alt_source [10] = '{22, 20, 18, 16, 14, 23, 21, 19, 17, 15};

    logic          clock;
    logic          reset_n;
    logic          pll_lock;
    logic          board_variant_n;
    logic          cfg_valid;
    divider_t      cfg_input_div;
    divider_t      cfg_output_div;
    divider_t      cfg_feedback_div;
    logic          cfg_use_half;
    pixel_t        pixel_in;
    logic          hsync_in;
    logic          vsync_in;
    logic          de_in;
    logic          sys_reset_n;
    logic          heartbeat_led;
    logic          cfg_ready;
    logic          pll_reset;
    pll_sel_t      pll_idsel;
    pll_sel_t      pll_odsel;
    pll_sel_t      pll_fbdsel;
    clock_select_t clock_sel;
    pixel_t        rgb_out;
    logic          rgb_hsync;
    logic          rgb_vsync;
    logic          rgb_de;

    int          checks;
    int          pixel_errors;
    int          sel_errors;
    int          clock_sel_errors;
    int          bit_errors;
    int          handshake_errors;
    int          total_errors;
    int unsigned seed_dummy;
    logic        cur_alt;

    display_top #(
        .RESET_STRETCH    (reset_stretch),
        .HEARTBEAT_PERIOD (heartbeat_period)
    ) u_display_top (.*);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // hard stop if a wait never ends
    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("run timed out after %0d cycles without reaching the end", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
        checks++;
        if (got !== exp) begin
            pixel_errors++;
            $display("ERR %0t ns: %s rgb_out %06h, expected %06h", $time, what, got, exp);
        end
    endtask

    task automatic check_sel(input pll_sel_t got, input pll_sel_t exp, input string what);
        checks++;
        if (got !== exp) begin
            sel_errors++;
            $display("ERR %0t ns: %s select %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_clock_sel(input clock_select_t got, input clock_select_t exp,
                                   input string what);
        checks++;
        if (got !== exp) begin
            clock_sel_errors++;
            $display("ERR %0t ns: %s clock_sel %04b, expected %04b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            bit_errors++;
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic pixel_t expected_pixel(input pixel_t pix, input logic alt);
        pixel_t res;
        res = pix;
        if (alt) begin
            for (int i = 0; i < 10; i++) begin
                res[14 + i] = pix[alt_source[i]];
            end
        end
        return res;
    endfunction

    // encoder state while the system reset is low
    task automatic check_encoder_reset(input string what);
        check_bit(pll_reset, 1'b1, {what, " pll_reset"});
        check_bit(cfg_ready, 1'b0, {what, " cfg_ready"});
        check_sel(pll_idsel, 6'd60, {what, " idsel"});
        check_sel(pll_odsel, 6'd60, {what, " odsel"});
        check_sel(pll_fbdsel, 6'd60, {what, " fbdsel"});
        check_clock_sel(clock_sel, 4'b0001, what);
    endtask

    // next edge is the first one with reset_n and pll_lock both high
    task automatic expect_release(input string what);
        for (int k = 0; k <= reset_stretch; k++) begin
            @(posedge clock);
            #drive_delay;
            check_bit(sys_reset_n, k == reset_stretch,
                      $sformatf("%s sys_reset_n at edge %0d", what, k));
        end
    endtask

    // reset with the strap pin set for the wanted board
    task automatic restart_board(input logic alt);
        reset_n         = 1'b0;
        board_variant_n = !alt;
        repeat (4) @(posedge clock);
        #drive_delay;
        reset_n = 1'b1;
        expect_release(alt ? "alt restart" : "straight restart");
        // strap latched here
        @(posedge clock);
        #drive_delay;
        // latch must hold against a later pin change
        board_variant_n = 1'b1;
    endtask

    task automatic apply_config(input cfg_row_t row, input int idx);
        int waited;
        waited           = 0;
        cfg_valid        = 1'b1;
        cfg_input_div    = row.input_div;
        cfg_output_div   = row.output_div;
        cfg_feedback_div = row.feedback_div;
        cfg_use_half     = row.use_half;
        while (!cfg_ready && waited < ready_wait_limit) begin
            @(posedge clock);
            #drive_delay;
            waited++;
        end
        if (!cfg_ready) begin
            handshake_errors++;
            $display("cfg_ready stayed low for %0d cycles, request %0d was never accepted",
                     waited, idx);
            cfg_valid = 1'b0;
        end else begin
            // transfer edge
            @(posedge clock);
            #drive_delay;
            cfg_valid = 1'b0;
            check_sel(pll_idsel, row.exp_idsel, $sformatf("cfg row %0d idsel", idx));
            check_sel(pll_odsel, row.exp_odsel, $sformatf("cfg row %0d odsel", idx));
            check_sel(pll_fbdsel, row.exp_fbdsel, $sformatf("cfg row %0d fbdsel", idx));
            check_clock_sel(clock_sel, row.exp_clock_sel, $sformatf("cfg row %0d", idx));
            check_bit(pll_reset, 1'b1, $sformatf("cfg row %0d pll_reset pulse", idx));
            check_bit(cfg_ready, 1'b0, $sformatf("cfg row %0d cfg_ready drop", idx));
            @(posedge clock);
            #drive_delay;
            check_bit(pll_reset, 1'b0, $sformatf("cfg row %0d pll_reset after pulse", idx));
            check_bit(cfg_ready, 1'b1, $sformatf("cfg row %0d cfg_ready back", idx));
        end
    endtask

    task automatic run_video_row(input video_row_t row, input int idx);
        logic [31:0] r;
        pixel_t      pix;
        pixel_t      exp_pix;
        logic        hs;
        logic        vs;
        logic        de;
        pix = row.pixel;
        hs  = row.hsync;
        vs  = row.vsync;
        de  = row.de;
        if (row.rnd) begin
            r   = $urandom();
            pix = r[23:0];
            r   = $urandom();
            hs  = r[0];
            vs  = r[1];
            de  = r[2];
        end
        exp_pix  = expected_pixel(pix, row.alt);
        pixel_in = pix;
        hsync_in = hs;
        vsync_in = vs;
        de_in    = de;
        // one cycle of latency
        @(posedge clock);
        #drive_delay;
        check_pixel(rgb_out, exp_pix, $sformatf("video row %0d", idx));
        check_bit(rgb_hsync, row.alt ? vs : hs, $sformatf("video row %0d rgb_hsync", idx));
        check_bit(rgb_vsync, row.alt ? hs : vs, $sformatf("video row %0d rgb_vsync", idx));
        check_bit(rgb_de, de, $sformatf("video row %0d rgb_de", idx));
        // inputs move on, outputs hold until the next edge
        pixel_in = ~pix;
        hsync_in = !hs;
        vsync_in = !vs;
        de_in    = !de;
        @(negedge clock);
        check_pixel(rgb_out, exp_pix, $sformatf("video row %0d mid-cycle", idx));
        check_bit(rgb_hsync, row.alt ? vs : hs, $sformatf("video row %0d hsync held", idx));
        check_bit(rgb_vsync, row.alt ? hs : vs, $sformatf("video row %0d vsync held", idx));
        check_bit(rgb_de, de, $sformatf("video row %0d rgb_de held", idx));
        @(posedge clock);
        #drive_delay;
    endtask

    initial begin
        // fixed seed for the random pixels
        seed_dummy       = $urandom(77990);
        checks           = 0;
        pixel_errors     = 0;
        sel_errors       = 0;
        clock_sel_errors = 0;
        bit_errors       = 0;
        handshake_errors = 0;
        cur_alt          = 1'b0;
        reset_n          = 1'b0;
        pll_lock         = 1'b0;
        board_variant_n  = 1'b1;
        cfg_valid        = 1'b0;
        cfg_input_div    = '0;
        cfg_output_div   = '0;
        cfg_feedback_div = '0;
        cfg_use_half     = 1'b0;
        // busy inputs so the blanked outputs mean something
        pixel_in         = 24'hffffff;
        hsync_in         = 1'b1;
        vsync_in         = 1'b1;
        de_in            = 1'b1;
        repeat (10) @(posedge clock);
        #drive_delay;
        check_bit(sys_reset_n, 1'b0, "in reset sys_reset_n");
        check_encoder_reset("in reset");
        check_bit(heartbeat_led, 1'b0, "in reset heartbeat_led");
        check_pixel(rgb_out, '0, "in reset");
        check_bit(rgb_hsync, 1'b0, "in reset rgb_hsync");
        check_bit(rgb_vsync, 1'b0, "in reset rgb_vsync");
        check_bit(rgb_de, 1'b0, "in reset rgb_de");
        reset_n  = 1'b1;
        pll_lock = 1'b1;
        expect_release("first release");
        // led toggles every HEARTBEAT_PERIOD+1 cycles after the release
        for (int j = 1; j <= 3 * (heartbeat_period + 1); j++) begin
            @(posedge clock);
            #drive_delay;
            check_bit(heartbeat_led, ((j / (heartbeat_period + 1)) % 2) == 1,
                      $sformatf("heartbeat_led %0d cycles after release", j));
        end
        check_bit(cfg_ready, 1'b1, "idle cfg_ready");
        check_bit(pll_reset, 1'b0, "idle pll_reset");
        for (int i = 0; i < cfg_rows; i++) begin
            apply_config(cfg_table[i], i);
        end
        // lock loss pulls everything back into reset
        pll_lock = 1'b0;
        @(posedge clock);
        #drive_delay;
        check_bit(sys_reset_n, 1'b0, "edge after lock loss sys_reset_n");
        @(posedge clock);
        #drive_delay;
        check_encoder_reset("after lock loss");
        check_pixel(rgb_out, '0, "after lock loss");
        pll_lock = 1'b1;
        expect_release("lock regained");
        for (int i = 0; i < video_rows; i++) begin
            if (i == 0 || video_table[i].alt != cur_alt) begin
                restart_board(video_table[i].alt);
                cur_alt = video_table[i].alt;
            end
            run_video_row(video_table[i], i);
        end
        total_errors = pixel_errors + sel_errors + clock_sel_errors + bit_errors
                     + handshake_errors;
        $display("checks %0d, errors: pixel %0d, select %0d, clock_sel %0d, bit %0d, handshake %0d",
                 checks, pixel_errors, sel_errors, clock_sel_errors, bit_errors,
                 handshake_errors);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* testbench/display_top_asserts.sv */
// checks are disabled while sys_reset_n is low or unknown; only the config handshake is covered
`timescale 1ns/1ps

module display_top_asserts
    import clock_cfg_pkg::*;
(
    input logic          clock,
    input logic          sys_reset_n,
    input logic          cfg_valid,
    input logic          cfg_ready,
    input logic          pll_reset,
    input clock_select_t clock_sel
);

    logic transfer;

    // accepted request on this edge
    assign transfer = cfg_valid && cfg_ready;

    // pll reset pulse lasts one cycle
    pll_reset_pulse: assert property (
        @(posedge clock) disable iff (sys_reset_n !== 1'b1)
        transfer |=> pll_reset ##1 !pll_reset
    ) else $error("pll_reset after a transfer was not a single-cycle pulse");

    // back-pressure in the apply cycle
    ready_drop: assert property (
        @(posedge clock) disable iff (sys_reset_n !== 1'b1)
        transfer |=> !cfg_ready
    ) else $error("cfg_ready stayed high in the cycle after a transfer");

    // clock mux select never shows two or zero sources
    clock_sel_onehot: assert property (
        @(posedge clock) disable iff (sys_reset_n !== 1'b1)
        $onehot(clock_sel)
    ) else $error("clock_sel is not one-hot");

endmodule

bind display_top display_top_asserts u_display_top_asserts (
    .clock       (clock),
    .sys_reset_n (sys_reset_n),
    .cfg_valid   (cfg_valid),
    .cfg_ready   (cfg_ready),
    .pll_reset   (pll_reset),
    .clock_sel   (clock_sel)
);

/* hdl/display_top.sv */
// single clock domain; pll_lock and the strap pin must already be synchronous to clock
`timescale 1ns/1ps

module display_top
    import video_pkg::*, clock_cfg_pkg::*;
#(
    parameter int RESET_STRETCH    = 32,
    parameter int HEARTBEAT_PERIOD = 62_500_000
) (
    input  logic          clock,
    input  logic          reset_n,
    input  logic          pll_lock,
    input  logic          board_variant_n,
    input  logic          cfg_valid,
    input  divider_t      cfg_input_div,
    input  divider_t      cfg_output_div,
    input  divider_t      cfg_feedback_div,
    input  logic          cfg_use_half,
    input  pixel_t        pixel_in,
    input  logic          hsync_in,
    input  logic          vsync_in,
    input  logic          de_in,
    output logic          sys_reset_n,
    output logic          heartbeat_led,
    output logic          cfg_ready,
    output logic          pll_reset,
    output pll_sel_t      pll_idsel,
    output pll_sel_t      pll_odsel,
    output pll_sel_t      pll_fbdsel,
    output clock_select_t clock_sel,
    output pixel_t        rgb_out,
    output logic          rgb_hsync,
    output logic          rgb_vsync,
    output logic          rgb_de
);

    // variant flag from the latch to the pin mapper
    logic alt_board;

    // reset stretch, heartbeat and strap latch
    board_control #(
        .RESET_STRETCH    (RESET_STRETCH),
        .HEARTBEAT_PERIOD (HEARTBEAT_PERIOD)
    ) u_board_control (
        .clock           (clock),
        .reset_n         (reset_n),
        .pll_lock        (pll_lock),
        .board_variant_n (board_variant_n),
        .sys_reset_n     (sys_reset_n),
        .alt_board       (alt_board),
        .heartbeat_led   (heartbeat_led)
    );

    // clock configuration
    pll_config_encoder u_pll_config_encoder (
        .clock            (clock),
        .sys_reset_n      (sys_reset_n),
        .cfg_valid        (cfg_valid),
        .cfg_input_div    (cfg_input_div),
        .cfg_output_div   (cfg_output_div),
        .cfg_feedback_div (cfg_feedback_div),
        .cfg_use_half     (cfg_use_half),
        .cfg_ready        (cfg_ready),
        .pll_reset        (pll_reset),
        .pll_idsel        (pll_idsel),
        .pll_odsel        (pll_odsel),
        .pll_fbdsel       (pll_fbdsel),
        .clock_sel        (clock_sel)
    );

    // pixel output stage
    video_pin_mapper u_video_pin_mapper (
        .clock       (clock),
        .sys_reset_n (sys_reset_n),
        .alt_board   (alt_board),
        .pixel_in    (pixel_in),
        .hsync_in    (hsync_in),
        .vsync_in    (vsync_in),
        .de_in       (de_in),
        .rgb_out     (rgb_out),
        .rgb_hsync   (rgb_hsync),
        .rgb_vsync   (rgb_vsync),
        .rgb_de      (rgb_de)
    );

endmodule

/* hdl/video_pin_mapper.sv */
// one cycle of latency, no handshake; alt_board must stay stable while pixels flow
`timescale 1ns/1ps

module video_pin_mapper
    import video_pkg::*;
(
    input  logic   clock,
    input  logic   sys_reset_n,
    input  logic   alt_board,
    input  pixel_t pixel_in,
    input  logic   hsync_in,
    input  logic   vsync_in,
    input  logic   de_in,
    output pixel_t rgb_out,
    output logic   rgb_hsync,
    output logic   rgb_vsync,
    output logic   rgb_de
);

    pixel_t mapped;
    logic   hsync_mapped;
    logic   vsync_mapped;

    // bit remap ahead of the output register
    // everything passes by default
    always_comb begin
        mapped = pixel_in;
        if (alt_board) begin
            // upper colour bits follow the board table
            for (int i = swap_lo_bit; i <= swap_hi_bit; i++) begin
                mapped[i] = pixel_in[alt_bit_source[i]];
            end
        end
    end

    // syncs are crossed on the alternate board
    assign hsync_mapped = alt_board ? vsync_in : hsync_in;
    assign vsync_mapped = alt_board ? hsync_in : vsync_in;

    // output register
    // blank and syncs inactive in reset
    always_ff @(posedge clock) begin
        if (!sys_reset_n) begin
            rgb_out   <= '0;
            rgb_hsync <= 1'b0;
            rgb_vsync <= 1'b0;
            rgb_de    <= 1'b0;
        end else begin
            rgb_out   <= mapped;
            rgb_hsync <= hsync_mapped;
            rgb_vsync <= vsync_mapped;
            // data enable never moves
            rgb_de    <= de_in;
        end
    end

endmodule

/* hdl/pll_config_encoder.sv */
// accepts one request at a time; ready drops for one cycle after each accepted request
`timescale 1ns/1ps

module pll_config_encoder
    import clock_cfg_pkg::*;
(
    input  logic          clock,
    input  logic          sys_reset_n,
    input  logic          cfg_valid,
    input  divider_t      cfg_input_div,
    input  divider_t      cfg_output_div,
    input  divider_t      cfg_feedback_div,
    input  logic          cfg_use_half,
    output logic          cfg_ready,
    output logic          pll_reset,
    output pll_sel_t      pll_idsel,
    output pll_sel_t      pll_odsel,
    output pll_sel_t      pll_fbdsel,
    output clock_select_t clock_sel
);

    // hold while in reset, idle when ready, apply for the pll reset pulse
    typedef enum logic [1:0] {
        st_hold,
        st_idle,
        st_apply
    } cfg_state_t;

    cfg_state_t state;
    logic       transfer;

    assign transfer = cfg_valid && cfg_ready;

    // ready only while idle
    assign cfg_ready = (state == st_idle);

    // pll held in reset except while idle
    assign pll_reset = (state != st_idle);

    always_ff @(posedge clock) begin
        if (!sys_reset_n) begin
            state <= st_hold;
        end else begin
            case (state)
                st_hold:  state <= st_idle;
                st_idle:  state <= transfer ? st_apply : st_idle;
                st_apply: state <= st_idle;
                default:  state <= st_hold;
            endcase
        end
    end

    // select registers
    // loaded on the transfer edge, visible with the pll reset pulse
    always_ff @(posedge clock) begin
        if (!sys_reset_n) begin
            pll_idsel  <= pll_sel_default;
            pll_odsel  <= pll_sel_default;
            pll_fbdsel <= pll_sel_default;
            clock_sel  <= sel_full;
        end else if (transfer) begin
            pll_idsel  <= div_to_sel(cfg_input_div[div_field_width-1:0]);
            // output divider counts in steps of two
            pll_odsel  <= div_to_sel({1'b0, cfg_output_div[div_field_width-1:1]});
            pll_fbdsel <= div_to_sel(cfg_feedback_div[div_field_width-1:0]);
            clock_sel  <= cfg_use_half ? sel_half : sel_full;
        end
    end

endmodule

/* hdl/board_control.sv */
// RESET_STRETCH must be at least 1; pll_lock and board_variant_n are assumed already synchronous
`timescale 1ns/1ps

module board_control #(
    parameter int RESET_STRETCH    = 32,
    parameter int HEARTBEAT_PERIOD = 62_500_000
) (
    input  logic clock,
    input  logic reset_n,
    input  logic pll_lock,
    input  logic board_variant_n,
    output logic sys_reset_n,
    output logic alt_board,
    output logic heartbeat_led
);

    // counter wide enough to reach the period
    localparam int hb_width = (HEARTBEAT_PERIOD > 0) ? $clog2(HEARTBEAT_PERIOD + 1) : 1;
    localparam logic [hb_width-1:0] hb_limit = hb_width'(HEARTBEAT_PERIOD);

    logic [RESET_STRETCH-1:0] stretch_reg;
    logic [hb_width-1:0]      hb_count;
    logic                     variant_locked;
    logic                     hold;

    // either source keeps everything in reset
    assign hold = !reset_n || !pll_lock;

    // stretch register
    // refills with ones while held, drains one zero per cycle after
    always_ff @(posedge clock) begin
        if (hold) begin
            stretch_reg <= '1;
        end else begin
            stretch_reg <= stretch_reg >> 1;
        end
    end

    // output stage of the stretcher
    // drops on the first held edge, rises one edge after the register empties
    always_ff @(posedge clock) begin
        if (hold) begin
            sys_reset_n <= 1'b0;
        end else begin
            sys_reset_n <= !stretch_reg[0];
        end
    end

    // heartbeat divider
    // counts 0..HEARTBEAT_PERIOD, toggles on wrap
    always_ff @(posedge clock) begin
        if (!sys_reset_n) begin
            hb_count      <= '0;
            heartbeat_led <= 1'b0;
        end else if (hb_count < hb_limit) begin
            hb_count <= hb_count + 1'b1;
        end else begin
            hb_count      <= '0;
            heartbeat_led <= !heartbeat_led;
        end
    end

    // board variant latch
    // strap pin sampled once, first edge out of reset
    // pin is low on the alternate board
    always_ff @(posedge clock) begin
        if (!sys_reset_n) begin
            alt_board      <= 1'b0;
            variant_locked <= 1'b0;
        end else if (!variant_locked) begin
            alt_board      <= !board_variant_n;
            variant_locked <= 1'b1;
        end
    end

endmodule

/* hdl/clock_cfg_pkg.sv */
// video clock configuration types; only the low 6 bits of a divider reach the pll
package clock_cfg_pkg;

    // divider request as the core hands it over
    typedef logic [15:0] divider_t;

    // pll divider select field
    typedef logic [5:0] pll_sel_t;

    // one-hot clock mux select
    typedef logic [3:0] clock_select_t;

    // meaningful bits of a divider request
    localparam int div_field_width = 6;

    // select code is this base minus the divider
    localparam logic [div_field_width:0] sel_base = 7'd64;

    // undivided pll output
    localparam clock_select_t sel_full = 4'b0001;

    // half-rate pll output
    localparam clock_select_t sel_half = 4'b0010;

    // all three pll fields after reset
    localparam pll_sel_t pll_sel_default = 6'd60;

    // divider to select code
    // a divider of 0 wraps to select 0
    function automatic pll_sel_t div_to_sel(input logic [div_field_width-1:0] div);
        logic [div_field_width:0] diff;
        // one extra bit so 64 itself fits
        diff = sel_base - {1'b0, div};
        return diff[div_field_width-1:0];
    endfunction

endpackage

/* hdl/video_pkg.sv */
// pixel types and alternate-board bit map; the map covers only bits 14 to 23, lower bits pass
package video_pkg;

    // one rgb pixel as the video core delivers it
    typedef logic [23:0] pixel_t;

    // index into a pixel
    typedef logic [4:0] bit_index_t;

    // first and last bit of the swapped field
    localparam int swap_lo_bit = 14;
    localparam int swap_hi_bit = 23;

    // source bit for each output bit on the alternate board
    // indexed by output bit, swap_lo_bit first
    // even source bits land on 14..18, odd ones on 19..23
    localparam bit_index_t alt_bit_source [swap_lo_bit:swap_hi_bit] = '{
        // out 14
        5'd22,
        // out 15
        5'd20,
        // out 16
        5'd18,
        // out 17
        5'd16,
        // out 18
        5'd14,
        // out 19
        5'd23,
        // out 20
        5'd21,
        // out 21
        5'd19,
        // out 22
        5'd17,
        // out 23
        5'd15
    };

    // bits below swap_lo_bit and the data enable never move
    // hsync and vsync trade places on the same board variant

endpackage
